/* Makefile */
# Verilator build and run of the narrow network router testbench

VERILATOR ?= verilator
TOP       ?= floo_nw_router_tb
FILELIST  ?= floo_nw_router.f
BUILD_DIR ?= build
LOG       ?= sim.log
FAIL_MSG  ?= TESTS FAILED
PASS_MSG  ?= TESTS PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* floo_nw_router.f */
src/floo_pkg.sv
src/floo_fifo.sv
src/floo_route_xy.sv
src/floo_rr_arbiter.sv
src/floo_router.sv
src/floo_nw_router.sv
verification/floo_tb_clk_gen.sv
verification/floo_nw_router_tb.sv

/* src/floo_fifo.sv */
/*
 * Router input buffer
 * Circular buffer of Depth flits with valid/ready on both sides,
 * push and pop in the same cycle are accepted even when full
 */
`timescale 1ns/1ps

module floo_fifo import floo_pkg::*; #(
  parameter int unsigned Depth = 2
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       valid_i,
  output logic       ready_o,
  input  floo_flit_t data_i,
  output logic       valid_o,
  input  logic       ready_i,
  output floo_flit_t data_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  floo_flit_t mem_q [Depth];
  ptr_t       wr_ptr_q, rd_ptr_q;
  cnt_t       count_q;
  logic       full, push, pop;

  function automatic ptr_t ptr_inc(ptr_t ptr);
    if (ptr == ptr_t'(Depth - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign full    = (count_q == cnt_t'(Depth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  // A full buffer still accepts when the head leaves in the same cycle
  assign ready_o = !full || ready_i;
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* src/floo_nw_router.sv */
/*
 * Narrow network router node
 * Splits the request and response links of all five ports into channel
 * signals for two independent routers and packs their outputs back
 */
`timescale 1ns/1ps

module floo_nw_router import floo_pkg::*; #(
  parameter int unsigned InFifoDepth = 2,
  parameter bit          XYRouteOpt  = 1'b1
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Coordinate of this node
  input  id_t                      id_i,
  input  floo_req_t [NumDirs-1:0]  floo_req_i,
  output floo_req_t [NumDirs-1:0]  floo_req_o,
  input  floo_rsp_t [NumDirs-1:0]  floo_rsp_i,
  output floo_rsp_t [NumDirs-1:0]  floo_rsp_o
);

  logic       [NumDirs-1:0] req_valid_in, req_ready_out;
  logic       [NumDirs-1:0] req_valid_out, req_ready_in;
  floo_flit_t [NumDirs-1:0] req_in, req_out;

  logic       [NumDirs-1:0] rsp_valid_in, rsp_ready_out;
  logic       [NumDirs-1:0] rsp_valid_out, rsp_ready_in;
  floo_flit_t [NumDirs-1:0] rsp_in, rsp_out;

  for (genvar p = 0; p < NumDirs; p++) begin : gen_links
    // Request network
    assign req_valid_in[p]     = floo_req_i[p].valid;
    assign req_in[p]           = floo_req_i[p].req;
    assign floo_req_o[p].ready = req_ready_out[p];
    assign floo_req_o[p].valid = req_valid_out[p];
    assign floo_req_o[p].req   = req_out[p];
    assign req_ready_in[p]     = floo_req_i[p].ready;

    // Response network
    assign rsp_valid_in[p]     = floo_rsp_i[p].valid;
    assign rsp_in[p]           = floo_rsp_i[p].rsp;
    assign floo_rsp_o[p].ready = rsp_ready_out[p];
    assign floo_rsp_o[p].valid = rsp_valid_out[p];
    assign floo_rsp_o[p].rsp   = rsp_out[p];
    assign rsp_ready_in[p]     = floo_rsp_i[p].ready;
  end

  floo_router #(
    .InFifoDepth ( InFifoDepth ),
    .XYRouteOpt  ( XYRouteOpt  )
  ) i_req_router (
    .clk_i,
    .rst_n_i,
    .xy_id_i ( id_i          ),
    .valid_i ( req_valid_in  ),
    .ready_o ( req_ready_out ),
    .data_i  ( req_in        ),
    .valid_o ( req_valid_out ),
    .ready_i ( req_ready_in  ),
    .data_o  ( req_out       )
  );

  floo_router #(
    .InFifoDepth ( InFifoDepth ),
    .XYRouteOpt  ( XYRouteOpt  )
  ) i_rsp_router (
    .clk_i,
    .rst_n_i,
    .xy_id_i ( id_i          ),
    .valid_i ( rsp_valid_in  ),
    .ready_o ( rsp_ready_out ),
    .data_i  ( rsp_in        ),
    .valid_o ( rsp_valid_out ),
    .ready_i ( rsp_ready_in  ),
    .data_o  ( rsp_out       )
  );

endmodule

/* src/floo_pkg.sv */
/*
 * Shared types of the mesh router node
 * Node coordinates, flit layout, per-port link structs and the port
 * numbering used by both the request and the response network
 */
package floo_pkg;

  // Number of router ports, one per direction plus the local port
  localparam int unsigned NumDirs = 5;

  // Port numbering, also the index of every per-port array
  typedef enum logic [2:0] {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } route_dir_e;

  // One mesh coordinate
  typedef logic [1:0] coord_t;

  // Node coordinate
  typedef struct packed {
    coord_t x;
    coord_t y;
  } id_t;

  typedef logic [31:0] payload_t;

  typedef struct packed {
    id_t dst_id;
    id_t src_id;
  } hdr_t;

  // Single-flit packet, same shape on both networks
  typedef struct packed {
    hdr_t     hdr;
    payload_t payload;
  } floo_flit_t;

  // Request link, ready belongs to the opposite link of the same port
  typedef struct packed {
    logic       valid;
    logic       ready;
    floo_flit_t req;
  } floo_req_t;

  // Response link, same layout as the request link
  typedef struct packed {
    logic       valid;
    logic       ready;
    floo_flit_t rsp;
  } floo_rsp_t;

  // One bit per port, at most one bit set
  typedef logic [NumDirs-1:0] port_oh_t;

endpackage

/* src/floo_route_xy.sv */
/*
 * Dimension-ordered XY route computation
 * Resolves X first, then Y, and selects the local port on arrival
 */
`timescale 1ns/1ps

module floo_route_xy import floo_pkg::*; (
  input  id_t      dst_id_i,
  input  id_t      xy_id_i,
  output port_oh_t route_o
);

  logic x_gt, x_lt, y_gt, y_lt;

  assign x_gt = (dst_id_i.x > xy_id_i.x);
  assign x_lt = (dst_id_i.x < xy_id_i.x);
  assign y_gt = (dst_id_i.y > xy_id_i.y);
  assign y_lt = (dst_id_i.y < xy_id_i.y);

  always_comb begin
    route_o = '0;
    if (x_gt) begin
      route_o[East] = 1'b1;
    end else if (x_lt) begin
      route_o[West] = 1'b1;
    end else if (y_gt) begin
      // Same column, north is the direction of growing y
      route_o[North] = 1'b1;
    end else if (y_lt) begin
      route_o[South] = 1'b1;
    end else begin
      route_o[Local] = 1'b1;
    end
  end

endmodule

/* src/floo_router.sv */
/*
 * Five-port mesh router with XY routing
 * Input FIFOs feed per-port route units, one round-robin arbiter per
 * output selects a head flit and the crossbar steers it out
 */
`timescale 1ns/1ps

module floo_router import floo_pkg::*; #(
  parameter int unsigned InFifoDepth = 2,
  parameter bit          XYRouteOpt  = 1'b1
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  id_t                        xy_id_i,
  input  logic       [NumDirs-1:0]   valid_i,
  output logic       [NumDirs-1:0]   ready_o,
  input  floo_flit_t [NumDirs-1:0]   data_i,
  output logic       [NumDirs-1:0]   valid_o,
  input  logic       [NumDirs-1:0]   ready_i,
  output floo_flit_t [NumDirs-1:0]   data_o
);

  // Input side, indexed by input port
  logic       [NumDirs-1:0] head_valid;
  logic       [NumDirs-1:0] head_ready;
  floo_flit_t [NumDirs-1:0] head_data;
  port_oh_t                 route   [NumDirs];

  // Output side, indexed by output port then input port
  port_oh_t                 arb_req [NumDirs];
  port_oh_t                 gnt     [NumDirs];
  logic       [NumDirs-1:0] out_ack;

  for (genvar p = 0; p < NumDirs; p++) begin : gen_inputs
    floo_fifo #(
      .Depth ( InFifoDepth )
    ) i_in_fifo (
      .clk_i,
      .rst_n_i,
      .valid_i ( valid_i[p]    ),
      .ready_o ( ready_o[p]    ),
      .data_i  ( data_i[p]     ),
      .valid_o ( head_valid[p] ),
      .ready_i ( head_ready[p] ),
      .data_o  ( head_data[p]  )
    );

    floo_route_xy i_route_xy (
      .dst_id_i ( head_data[p].hdr.dst_id ),
      .xy_id_i  ( xy_id_i                 ),
      .route_o  ( route[p]                )
    );
  end

  // Transpose the per-input routes into per-output request vectors
  always_comb begin
    for (int o = 0; o < NumDirs; o++) begin
      for (int p = 0; p < NumDirs; p++) begin
        arb_req[o][p] = head_valid[p] & route[p][o];
        // XY traffic never turns from the Y axis back onto the X axis
        if (XYRouteOpt && (o == East || o == West) && (p == North || p == South)) begin
          arb_req[o][p] = 1'b0;
        end
      end
    end
  end

  for (genvar o = 0; o < NumDirs; o++) begin : gen_outputs
    floo_rr_arbiter i_rr_arbiter (
      .clk_i,
      .rst_n_i,
      .req_i ( arb_req[o] ),
      .gnt_o ( gnt[o]     ),
      .ack_i ( out_ack[o] )
    );

    assign valid_o[o] = |gnt[o];
    assign out_ack[o] = valid_o[o] & ready_i[o];
  end

  // AND-OR crossbar, a masked path folds away to a constant
  always_comb begin
    for (int o = 0; o < NumDirs; o++) begin
      data_o[o] = '0;
      for (int p = 0; p < NumDirs; p++) begin
        if (gnt[o][p]) data_o[o] = data_o[o] | head_data[p];
      end
    end
  end

  // Pop the head that wins an output which accepts this cycle
  always_comb begin
    head_ready = '0;
    for (int p = 0; p < NumDirs; p++) begin
      for (int o = 0; o < NumDirs; o++) begin
        if (gnt[o][p] && ready_i[o]) head_ready[p] = 1'b1;
      end
    end
  end

endmodule

/* src/floo_rr_arbiter.sv */
/*
 * Round-robin arbiter for one router output
 * Picks the first requester at or after the priority pointer and holds
 * that grant until the flit has been accepted downstream
 */
`timescale 1ns/1ps

module floo_rr_arbiter import floo_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  port_oh_t req_i,
  output port_oh_t gnt_o,
  input  logic     ack_i
);

  route_dir_e ptr_q, winner, next_ptr;
  port_oh_t   rr_gnt, gnt_q;
  logic       lock_q;

  // Fresh round-robin pick, wrapping past the last port
  always_comb begin
    int unsigned idx;
    logic        found;
    rr_gnt = '0;
    found  = 1'b0;
    for (int unsigned i = 0; i < NumDirs; i++) begin
      idx = int'(ptr_q) + i;
      if (idx >= NumDirs) idx = idx - NumDirs;
      if (!found && req_i[idx]) begin
        found       = 1'b1;
        rr_gnt[idx] = 1'b1;
      end
    end
  end

  // A waiting flit keeps its grant so the output data stays stable
  assign gnt_o = lock_q ? gnt_q : rr_gnt;

  always_comb begin
    winner = ptr_q;
    for (int unsigned i = 0; i < NumDirs; i++) begin
      if (gnt_o[i]) winner = route_dir_e'(i);
    end
    next_ptr = (winner == West) ? Local : route_dir_e'(winner + 1'b1);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q  <= Local;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      if ((|gnt_o) && !ack_i) begin
        lock_q <= 1'b1;
        gnt_q  <= gnt_o;
      end else if (ack_i) begin
        lock_q <= 1'b0;
      end
      if (ack_i) ptr_q <= next_ptr;
    end
  end

endmodule

/* verification/floo_nw_router_tb.sv */
/*
 * Testbench for the narrow network router node
 * Sends legal XY traffic into both networks, predicts the output port of
 * every flit and checks delivery, order, back-pressure and independence
 */
`timescale 1ns/1ps

module floo_nw_router_tb import floo_pkg::*; ();

  localparam int          NumNets = 2;
  localparam int          ReqNet  = 0;
  localparam int          RspNet  = 1;
  localparam int          Timeout = 2000;
  localparam logic [31:0] Seed    = 32'h7882_af7e;
  localparam id_t         NodeId  = '{x: 2'd1, y: 2'd1};
  localparam logic [1:0]  ReadyOpen = 2'd0;
  localparam logic [1:0]  ReadyHold = 2'd1;
  localparam logic [1:0]  ReadyRand = 2'd2;

  logic                    clk_i, rst_n_i;
  floo_req_t [NumDirs-1:0] floo_req_i, floo_req_o;
  floo_rsp_t [NumDirs-1:0] floo_rsp_i, floo_rsp_o;

  logic       drv_valid  [NumNets][NumDirs];
  floo_flit_t drv_flit   [NumNets][NumDirs];
  logic       drv_ready  [NumNets][NumDirs];
  logic [1:0] ready_mode [NumNets][NumDirs];
  port_oh_t   rand_ready [NumNets];
  // Expected flits by network, output port and source input
  floo_flit_t exp_q      [NumNets][NumDirs][NumDirs][$];
  logic       stall_q    [NumNets][NumDirs];
  floo_flit_t held_q     [NumNets][NumDirs];
  int         in_count = 0;
  int         out_count = 0;

  floo_tb_clk_gen #(.PeriodNs(10), .ResetCycles(5)) u_clk_gen (
    .clk_o   ( clk_i   ),
    .rst_n_o ( rst_n_i )
  );

  floo_nw_router u_floo_nw_router (
    .clk_i, .rst_n_i, .id_i(NodeId), .floo_req_i, .floo_req_o, .floo_rsp_i, .floo_rsp_o
  );

  always @(negedge clk_i) begin
    for (int n = 0; n < NumNets; n++) rand_ready[n] = port_oh_t'($urandom);
  end

  always_comb begin
    for (int n = 0; n < NumNets; n++) begin
      for (int o = 0; o < NumDirs; o++) begin
        case (ready_mode[n][o])
          ReadyHold: drv_ready[n][o] = 1'b0;
          ReadyRand: drv_ready[n][o] = rand_ready[n][o];
          default:   drv_ready[n][o] = 1'b1;
        endcase
      end
    end
    for (int p = 0; p < NumDirs; p++) begin
      floo_req_i[p] = '{valid: drv_valid[ReqNet][p], ready: drv_ready[ReqNet][p],
                        req: drv_flit[ReqNet][p]};
      floo_rsp_i[p] = '{valid: drv_valid[RspNet][p], ready: drv_ready[RspNet][p],
                        rsp: drv_flit[RspNet][p]};
    end
  end

  // Reference XY model of the node at NodeId
  function automatic route_dir_e xy_port(id_t dst);
    if (dst.x > NodeId.x) return East;
    if (dst.x < NodeId.x) return West;
    if (dst.y > NodeId.y) return North;
    if (dst.y < NodeId.y) return South;
    return Local;
  endfunction

  // Each input is tagged by the coordinate of its neighbour
  function automatic id_t port_src_id(route_dir_e p);
    case (p)
      North:   return '{x: 2'd1, y: 2'd2};
      East:    return '{x: 2'd2, y: 2'd1};
      South:   return '{x: 2'd1, y: 2'd0};
      West:    return '{x: 2'd0, y: 2'd1};
      default: return NodeId;
    endcase
  endfunction

  function automatic route_dir_e src_port(id_t src);
    for (int p = 0; p < NumDirs; p++) begin
      if (port_src_id(route_dir_e'(p)) == src) return route_dir_e'(p);
    end
    return Local;
  endfunction

  // Y inputs stay in their column and no flit turns back
  function automatic floo_flit_t make_flit(route_dir_e p, logic to_local);
    floo_flit_t f;
    f.hdr.src_id = port_src_id(p);
    f.payload    = payload_t'($urandom);
    f.hdr.dst_id = (p == South) ? port_src_id(North) : port_src_id(South);
    if (to_local) f.hdr.dst_id = NodeId;
    for (int i = 0; i < 64 && !to_local; i++) begin
      f.hdr.dst_id = '{x: coord_t'($urandom_range(2, 0)), y: coord_t'($urandom_range(2, 0))};
      if (xy_port(f.hdr.dst_id) != p &&
          !((p == North || p == South) && f.hdr.dst_id.x != NodeId.x)) break;
    end
    return f;
  endfunction

  function automatic logic in_ready(int n, route_dir_e p);
    return (n == ReqNet) ? floo_req_o[p].ready : floo_rsp_o[p].ready;
  endfunction

  function automatic logic out_valid(int n, int o);
    return (n == ReqNet) ? floo_req_o[o].valid : floo_rsp_o[o].valid;
  endfunction

  function automatic floo_flit_t out_flit(int n, int o);
    return (n == ReqNet) ? floo_req_o[o].req : floo_rsp_o[o].rsp;
  endfunction

  function automatic int pending(int n);
    int total;
    total = 0;
    for (int o = 0; o < NumDirs; o++) begin
      for (int p = 0; p < NumDirs; p++) total += exp_q[n][o][p].size();
    end
    return total;
  endfunction

  task automatic stop_with_error(string what);
    $display("ERROR at time %0t: %s", $time, what);
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(int n, int o, string field, logic [63:0] exp, logic [63:0] act);
    $display("FAIL time %0t %s[%0d].%s expected %0h actual %0h", $time,
             (n == ReqNet) ? "floo_req_o" : "floo_rsp_o", o, field, exp, act);
    stop_with_error("output value differs from the model");
  endtask

  task automatic wait_accept(int n, route_dir_e p);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > Timeout) stop_with_error($sformatf("input %s never accepted", p.name()));
    end while (!in_ready(n, p));
  endtask

  task automatic send_stream(int n, route_dir_e p, int count, logic to_local);
    for (int i = 0; i < count; i++) begin
      @(negedge clk_i);
      drv_flit[n][p]  = make_flit(p, to_local);
      drv_valid[n][p] = 1'b1;
      wait_accept(n, p);
    end
    @(negedge clk_i);
    drv_valid[n][p] = 1'b0;
  endtask

  task automatic send_all_ports(int n, int count);
    fork
      send_stream(n, Local, count, 1'b0);
      send_stream(n, North, count, 1'b0);
      send_stream(n, East, count, 1'b0);
      send_stream(n, South, count, 1'b0);
      send_stream(n, West, count, 1'b0);
    join
  endtask

  task automatic wait_drained(int n);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (pending(n) != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) stop_with_error("expected flits were never delivered");
    end
  endtask

  task automatic set_ready_all(logic [1:0] mode);
    @(negedge clk_i);
    for (int n = 0; n < NumNets; n++) begin
      for (int o = 0; o < NumDirs; o++) ready_mode[n][o] = mode;
    end
  endtask

  // Records every accepted flit and checks every output transfer
  always @(posedge clk_i) begin
    floo_flit_t f, exp_f;
    route_dir_e src;
    for (int n = 0; n < NumNets; n++) begin
      for (int o = 0; o < NumDirs; o++) begin
        if (!rst_n_i) begin
          assert (!out_valid(n, o)) else report_mismatch(n, o, "valid", 64'd0, 64'd1);
          stall_q[n][o] = 1'b0;
          continue;
        end
        if (drv_valid[n][o] && in_ready(n, route_dir_e'(o))) begin
          f = drv_flit[n][o];
          exp_q[n][int'(xy_port(f.hdr.dst_id))][o].push_back(f);
          in_count++;
        end
        // A stalled output keeps its flit until it is taken
        if (stall_q[n][o]) begin
          assert (out_valid(n, o)) else report_mismatch(n, o, "valid", 64'd1, 64'd0);
          assert (out_flit(n, o) == held_q[n][o])
            else report_mismatch(n, o, "data", 64'(held_q[n][o]), 64'(out_flit(n, o)));
        end
        stall_q[n][o] = out_valid(n, o) && !drv_ready[n][o];
        held_q[n][o]  = out_flit(n, o);
        if (out_valid(n, o) && drv_ready[n][o]) begin
          f   = out_flit(n, o);
          src = src_port(f.hdr.src_id);
          assert (xy_port(f.hdr.dst_id) == route_dir_e'(o))
            else report_mismatch(n, o, "port", 64'(xy_port(f.hdr.dst_id)), 64'(o));
          assert (exp_q[n][o][int'(src)].size() != 0)
            else stop_with_error($sformatf("unexpected flit from %s at port %0d", src.name(), o));
          exp_f = exp_q[n][o][int'(src)].pop_front();
          assert (f == exp_f) else report_mismatch(n, o, "data", 64'(exp_f), 64'(f));
          out_count++;
        end
      end
    end
  end

  initial begin
    int   cycles;
    logic accepted;
    void'($urandom(Seed));
    for (int n = 0; n < NumNets; n++) begin
      for (int p = 0; p < NumDirs; p++) begin
        drv_valid[n][p]  = 1'b0;
        drv_flit[n][p]   = '0;
        ready_mode[n][p] = ReadyOpen;
      end
    end
    cycles = 0;
    while (rst_n_i !== 1'b1) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > Timeout) stop_with_error("reset was never released");
    end
    @(negedge clk_i);
    for (int o = 0; o < NumDirs; o++) begin
      assert (!out_valid(ReqNet, o)) else report_mismatch(ReqNet, o, "valid", 64'd0, 64'd1);
      assert (!out_valid(RspNet, o)) else report_mismatch(RspNet, o, "valid", 64'd0, 64'd1);
    end
    // Random legal routes on both networks
    fork
      send_all_ports(ReqNet, 16);
      send_all_ports(RspNet, 16);
    join
    wait_drained(ReqNet);
    wait_drained(RspNet);
    // Back-pressure on the request East output until Local input blocks
    @(negedge clk_i);
    ready_mode[ReqNet][East] = ReadyHold;
    cycles = 0;
    do begin
      drv_flit[ReqNet][Local]  = make_flit(Local, 1'b0);
      drv_flit[ReqNet][Local].hdr.dst_id = port_src_id(East);
      drv_valid[ReqNet][Local] = 1'b1;
      @(posedge clk_i);
      accepted = in_ready(ReqNet, Local);
      @(negedge clk_i);
      cycles++;
      if (cycles > 16) stop_with_error("Local input ready never dropped under back-pressure");
    end while (accepted);
    repeat (16) @(negedge clk_i);
    ready_mode[ReqNet][East] = ReadyOpen;
    wait_accept(ReqNet, Local);
    @(negedge clk_i);
    drv_valid[ReqNet][Local] = 1'b0;
    wait_drained(ReqNet);
    // Responses flow while every request output is stalled
    set_ready_all(ReadyHold);
    for (int o = 0; o < NumDirs; o++) ready_mode[RspNet][o] = ReadyOpen;
    send_all_ports(ReqNet, 2);
    send_all_ports(RspNet, 12);
    wait_drained(RspNet);
    assert (pending(ReqNet) == 2 * NumDirs)
      else stop_with_error("request flits moved while all request outputs were stalled");
    set_ready_all(ReadyOpen);
    wait_drained(ReqNet);
    // Four inputs compete for Local under random ready
    ready_mode[ReqNet][Local] = ReadyRand;
    ready_mode[RspNet][Local] = ReadyRand;
    fork
      send_stream(ReqNet, North, 20, 1'b1);
      send_stream(ReqNet, East, 20, 1'b1);
      send_stream(ReqNet, South, 20, 1'b1);
      send_stream(ReqNet, West, 20, 1'b1);
      send_stream(RspNet, North, 20, 1'b1);
      send_stream(RspNet, East, 20, 1'b1);
      send_stream(RspNet, South, 20, 1'b1);
      send_stream(RspNet, West, 20, 1'b1);
    join
    wait_drained(ReqNet);
    wait_drained(RspNet);
    // Mixed traffic with random ready everywhere
    set_ready_all(ReadyRand);
    fork
      send_all_ports(ReqNet, 24);
      send_all_ports(RspNet, 24);
    join
    wait_drained(ReqNet);
    wait_drained(RspNet);
    if (pending(ReqNet) == 0 && pending(RspNet) == 0 && in_count == out_count) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      stop_with_error("flits are still outstanding at the end of the run");
    end
  end

endmodule

/* verification/floo_tb_clk_gen.sv */
/*
 * Testbench clock and reset generator
 * Free-running clock and an active-low reset held for a number of cycles
 */
`timescale 1ns/1ps

module floo_tb_clk_gen #(
  parameter int unsigned PeriodNs    = 10,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, like every other DUT input
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule
